// File: include/bus68020_defines.svh
/*
 * Width and port-size constants for the 68020 bus interface unit
 * Also holds the wait-state limit used by the slave model
 */
`ifndef BUS68020_DEFINES_SVH
`define BUS68020_DEFINES_SVH

// Bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// Bytes per port width as reported on nDSACK
`define PORT8_BYTES  1
`define PORT16_BYTES 2
`define PORT32_BYTES 4

// Largest number of wait states the slave inserts
`define TB_MAX_WAIT 3

`endif

// File: rtl/bus68020Pkg.sv
/*
 * Shared types of the 68020 bus interface unit
 * SIZ and DSACK encodings plus the sequencer and tracker states
 */
package bus68020Pkg;

    // Four bytes encode as 00
    typedef enum logic [1:0] {
        size4 = 2'b00,
        size1 = 2'b01,
        size2 = 2'b10,
        size3 = 2'b11
    } xferSize;

    // Active low acknowledge pair
    typedef enum logic [1:0] {
        dsack32   = 2'b00,
        dsack16   = 2'b01,
        dsack8    = 2'b10,
        dsackWait = 2'b11  // Nothing asserted yet
    } dsackCode;

    typedef enum logic [1:0] {
        seqIdle    = 2'b00,
        seqStrobe  = 2'b01,
        seqRecover = 2'b10
    } seqState;

    typedef enum logic [1:0] {
        trackIdle   = 2'b00,
        trackActive = 2'b01,
        trackFinish = 2'b10
    } trackState;

endpackage

// File: rtl/cycleIf.sv
/*
 * One external bus cycle as seen by the three stages
 * Tracker issues it, sequencer runs it, router moves its data
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

interface cycleIf;

    logic                   start;
    logic [`BUS_ADDR_W-1:0] addr;
    bus68020Pkg::xferSize   size;
    logic                   write;
    logic [2:0]             xferBytes;  // Bytes moved by the ending cycle
    logic                   ack;
    bus68020Pkg::dsackCode  port;
    logic [`BUS_DATA_W-1:0] rdLanes;

    modport tracker (
        output start, addr, size, write, xferBytes,
        input  ack, port
    );
    modport sequencer (
        input  start, addr, size, write,
        output ack, port, rdLanes
    );
    modport router (
        input start, addr, size, write, xferBytes, ack, port, rdLanes
    );

endinterface

// File: rtl/sizingTracker.sv
/*
 * Request tracker with dynamic bus sizing
 * Latches a 1 to 4 byte request, then issues one bus cycle after another,
 * stepping the address and remaining count by what each port accepted
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module sizingTracker (
    input  logic                   CLK,
    input  logic                   in_RESET,
    input  logic                   reqValid,
    input  logic                   reqWrite,
    input  logic [`BUS_ADDR_W-1:0] reqAddr,
    input  bus68020Pkg::xferSize   reqSize,
    output logic                   busy,
    output logic                   done,
    cycleIf.tracker                cyc
);

    bus68020Pkg::trackState state;
    logic [`BUS_ADDR_W-1:0] curAddr;
    logic [2:0]             remain;
    logic                   isWrite;
    logic [2:0]             portBytes;
    logic [2:0]             room;
    logic                   accept;
    logic                   lastCycle;

    assign accept    = reqValid && !busy;
    assign lastCycle = (cyc.xferBytes == remain);

    assign cyc.addr  = curAddr;
    assign cyc.size  = bus68020Pkg::xferSize'(remain[1:0]);  // Count 4 maps onto 00
    assign cyc.write = isWrite;

    // Bytes the acknowledging port takes at this address
    always_comb begin
        case (cyc.port)
            bus68020Pkg::dsack32: portBytes = 3'(`PORT32_BYTES);
            bus68020Pkg::dsack16: portBytes = 3'(`PORT16_BYTES);
            default:              portBytes = 3'(`PORT8_BYTES);
        endcase
        room = portBytes - (curAddr[2:0] & (portBytes - 3'd1));
        cyc.xferBytes = (remain < room) ? remain : room;
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            curAddr <= reqAddr;
            remain  <= (reqSize == bus68020Pkg::size4) ? 3'd4 : {1'b0, reqSize};
            isWrite <= reqWrite;
        end else if (cyc.ack) begin
            curAddr <= curAddr + `BUS_ADDR_W'(cyc.xferBytes);
            remain  <= remain - cyc.xferBytes;
        end
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state     <= bus68020Pkg::trackIdle;
            busy      <= 1'b0;
            done      <= 1'b0;
            cyc.start <= 1'b0;
        end else begin
            cyc.start <= 1'b0;
            done      <= 1'b0;
            case (state)
                bus68020Pkg::trackActive: begin
                    if (cyc.ack && lastCycle) begin
                        state <= bus68020Pkg::trackFinish;
                        busy  <= 1'b0;
                        done  <= 1'b1;  // Lands in the recover cycle
                    end else if (cyc.ack) begin
                        cyc.start <= 1'b1;  // Next cycle starts from recover
                    end
                end
                default: begin  // Idle and finish both take a new request
                    if (accept) begin
                        state     <= bus68020Pkg::trackActive;
                        busy      <= 1'b1;
                        cyc.start <= 1'b1;
                    end else begin
                        state <= bus68020Pkg::trackIdle;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/cycleSequencer.sv
/*
 * Bus cycle sequencer
 * Drives A, SIZ, RnW and the strobes for one cycle at a time and
 * holds them until nDSACK reports a port width, then recovers
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module cycleSequencer (
    input  logic                   CLK,
    input  logic                   in_RESET,
    cycleIf.sequencer              cyc,
    output logic [`BUS_ADDR_W-1:0] A,
    output bus68020Pkg::xferSize   SIZ,
    output logic                   RnW,
    output logic                   nAS,
    output logic                   nDS,
    input  logic [`BUS_DATA_W-1:0] dIn,
    input  bus68020Pkg::dsackCode  nDSACK
);

    bus68020Pkg::seqState   state;
    bus68020Pkg::dsackCode  portHold;
    logic [`BUS_DATA_W-1:0] lanesHold;
    logic                   strobing;

    assign strobing = (state == bus68020Pkg::seqStrobe);

    // Live values while strobing, held copies afterwards
    assign cyc.ack     = strobing && (nDSACK != bus68020Pkg::dsackWait);
    assign cyc.port    = strobing ? nDSACK : portHold;
    assign cyc.rdLanes = strobing ? dIn : lanesHold;

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state <= bus68020Pkg::seqIdle;
            A     <= '0;
            SIZ   <= bus68020Pkg::size4;
            RnW   <= 1'b1;
            nAS   <= 1'b1;
            nDS   <= 1'b1;
        end else begin
            case (state)
                bus68020Pkg::seqStrobe: begin
                    if (cyc.ack) begin
                        state <= bus68020Pkg::seqRecover;
                        nAS   <= 1'b1;
                        nDS   <= 1'b1;
                    end
                end
                default: begin
                    if (cyc.start) begin
                        state <= bus68020Pkg::seqStrobe;
                        A     <= cyc.addr;
                        SIZ   <= cyc.size;
                        RnW   <= !cyc.write;
                        nAS   <= 1'b0;
                        nDS   <= 1'b0;
                    end else begin
                        state <= bus68020Pkg::seqIdle;
                        RnW   <= 1'b1;  // Bus parks in read
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (cyc.ack) begin
            portHold  <= nDSACK;
            lanesHold <= dIn;
        end
    end

endmodule

// File: rtl/laneRouter.sv
/*
 * Byte lane router
 * Write side puts the remaining operand bytes on the lanes picked by
 * SIZ and A[1:0], copying leading bytes into unused lanes.
 * Read side merges each acknowledged cycle into a right-justified result
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module laneRouter (
    input  logic                   CLK,
    input  logic                   in_RESET,
    cycleIf.router                 cyc,
    input  logic [`BUS_DATA_W-1:0] reqData,
    input  logic                   reqValid,
    input  logic                   busy,
    output logic [`BUS_DATA_W-1:0] rdData,
    output logic [`BUS_DATA_W-1:0] dOut,
    output logic                   dOe
);

    logic [`BUS_DATA_W-1:0] opData;
    logic [`BUS_DATA_W-1:0] msbFirst;
    logic [`BUS_DATA_W-1:0] placed;
    logic [`BUS_DATA_W-1:0] gathered;
    logic [7:0]             opByte [4];
    logic [2:0]             remBytes;
    logic [2:0]             portBytes;
    logic [1:0]             laneOff;

    assign remBytes = (cyc.size == bus68020Pkg::size4) ? 3'd4 : {1'b0, cyc.size};
    assign msbFirst = opData << {3'd4 - remBytes, 3'b000};  // Next byte to send at top

    always_comb begin
        case (cyc.port)
            bus68020Pkg::dsack32: portBytes = 3'(`PORT32_BYTES);
            bus68020Pkg::dsack16: portBytes = 3'(`PORT16_BYTES);
            default:              portBytes = 3'(`PORT8_BYTES);
        endcase
        laneOff = cyc.addr[1:0] & 2'(portBytes - 3'd1);
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            opByte[i] = msbFirst[`BUS_DATA_W - 1 - 8 * i -: 8];
        end
        // Short operands repeat their leading bytes
        case (remBytes)
            3'd1: begin
                opByte[1] = opByte[0];
                opByte[2] = opByte[0];
                opByte[3] = opByte[0];
            end
            3'd2: begin
                opByte[2] = opByte[0];
                opByte[3] = opByte[1];
            end
            3'd3: opByte[3] = opByte[0];
            default: ;
        endcase
        case (cyc.addr[1:0])
            2'b00:   placed = {opByte[0], opByte[1], opByte[2], opByte[3]};
            2'b01:   placed = {opByte[0], opByte[0], opByte[1], opByte[2]};
            2'b10:   placed = {opByte[0], opByte[1], opByte[0], opByte[1]};
            default: placed = {opByte[0], opByte[0], opByte[1], opByte[0]};
        endcase
    end

    // Lane k of this cycle is operand byte remBytes-1-k from the bottom
    always_comb begin
        gathered = rdData;
        for (int k = 0; k < 4; k++) begin
            if (k < int'(cyc.xferBytes)) begin
                gathered[8 * (int'(remBytes) - 1 - k) +: 8] =
                    cyc.rdLanes[8 * (3 - int'(laneOff) - k) +: 8];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reqValid && !busy) begin
            opData <= reqData;
            rdData <= '0;
        end else if (cyc.ack && !cyc.write) begin
            rdData <= gathered;
        end
        if (cyc.start) begin
            dOut <= placed;
        end
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            dOe <= 1'b0;
        end else if (cyc.start) begin
            dOe <= cyc.write;
        end else if (cyc.ack) begin
            dOe <= 1'b0;  // Released with the strobes
        end
    end

endmodule

// File: rtl/bus68020.sv
/*
 * 68020-style bus interface unit
 * Splits internal 1 to 4 byte requests into 8, 16 or 32 bit bus cycles
 * through a tracker, a cycle sequencer and a byte lane router
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module bus68020 (
    input  logic                   CLK,
    input  logic                   in_RESET,
    input  logic                   reqValid,
    input  logic                   reqWrite,
    input  logic [`BUS_ADDR_W-1:0] reqAddr,
    input  logic [`BUS_DATA_W-1:0] reqData,
    input  bus68020Pkg::xferSize   reqSize,
    output logic                   busy,
    output logic                   done,
    output logic [`BUS_DATA_W-1:0] rdData,
    output logic [`BUS_ADDR_W-1:0] A,
    output bus68020Pkg::xferSize   SIZ,
    output logic                   RnW,
    output logic                   nAS,
    output logic                   nDS,
    output logic                   dOe,
    output logic [`BUS_DATA_W-1:0] dOut,
    input  logic [`BUS_DATA_W-1:0] dIn,
    input  bus68020Pkg::dsackCode  nDSACK
);

    cycleIf cyc ();

    sizingTracker tracker (
        .CLK      (CLK),
        .in_RESET (in_RESET),
        .reqValid (reqValid),
        .reqWrite (reqWrite),
        .reqAddr  (reqAddr),
        .reqSize  (reqSize),
        .busy     (busy),
        .done     (done),
        .cyc      (cyc)
    );

    cycleSequencer sequencer (
        .CLK      (CLK),
        .in_RESET (in_RESET),
        .cyc      (cyc),
        .A        (A),
        .SIZ      (SIZ),
        .RnW      (RnW),
        .nAS      (nAS),
        .nDS      (nDS),
        .dIn      (dIn),
        .nDSACK   (nDSACK)
    );

    laneRouter router (
        .CLK      (CLK),
        .in_RESET (in_RESET),
        .cyc      (cyc),
        .reqData  (reqData),
        .reqValid (reqValid),
        .busy     (busy),
        .rdData   (rdData),
        .dOut     (dOut),
        .dOe      (dOe)
    );

endmodule

// File: sim/bus68020_assertions.sv
/*
 * Bus protocol checks bound into the 68020 bus interface unit
 * Strobe order, address hold, data enable direction and busy span
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module bus68020_assertions (
    input logic                   CLK,
    input logic                   in_RESET,
    input logic                   reqValid,
    input logic                   busy,
    input logic                   done,
    input logic [`BUS_ADDR_W-1:0] A,
    input bus68020Pkg::xferSize   SIZ,
    input logic                   RnW,
    input logic                   nAS,
    input logic                   nDS,
    input logic                   dOe
);

    bus68020Pkg::seqState lastPhase;  // Strobe when nAS was low last cycle

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            lastPhase <= bus68020Pkg::seqIdle;
        end else if (!nAS) begin
            lastPhase <= bus68020Pkg::seqStrobe;
        end else if (lastPhase == bus68020Pkg::seqStrobe) begin
            lastPhase <= bus68020Pkg::seqRecover;
        end else begin
            lastPhase <= bus68020Pkg::seqIdle;
        end
    end

    strobeOrder: assert property (@(posedge CLK) disable iff (!in_RESET) nAS |-> nDS)
        else $error("nDS asserted while nAS is negated");

    addrHold: assert property (@(posedge CLK) disable iff (!in_RESET)
        (!nAS && lastPhase == bus68020Pkg::seqStrobe) |-> ($stable(A) && $stable(SIZ)))
        else $error("A or SIZ changed during an address strobe");

    driveDir: assert property (@(posedge CLK) disable iff (!in_RESET) dOe |-> !RnW)
        else $error("dOe high during a read cycle");

    busySpan: assert property (@(posedge CLK) disable iff (!in_RESET)
        ($past(reqValid && !busy) || $past(busy)) |-> (busy || done))
        else $error("busy dropped before done");

endmodule

bind bus68020 bus68020_assertions protocolChecks (
    .CLK      (CLK),
    .in_RESET (in_RESET),
    .reqValid (reqValid),
    .busy     (busy),
    .done     (done),
    .A        (A),
    .SIZ      (SIZ),
    .RnW      (RnW),
    .nAS      (nAS),
    .nDS      (nDS),
    .dOe      (dOe)
);

// File: sim/tb_bus68020.sv
/*
 * Testbench for the 68020 bus interface unit
 * A byte memory slave answers on an 8, 16 or 32 bit port after random
 * wait states, and a reference model predicts read data, memory and cycles
 */
`timescale 1ns/1ps
`include "bus68020_defines.svh"

module tb_bus68020;

    localparam int MemBytes   = 256;
    localparam int NumReqs    = 9 + 48 + 48 + 200;
    localparam int WatchdogNs = NumReqs * 4 * (`TB_MAX_WAIT + 2) * 10 + 20000;

    logic                   CLK;
    logic                   in_RESET;
    logic                   reqValid;
    logic                   reqWrite;
    logic [`BUS_ADDR_W-1:0] reqAddr;
    logic [`BUS_DATA_W-1:0] reqData;
    bus68020Pkg::xferSize   reqSize;
    logic                   busy;
    logic                   done;
    logic [`BUS_DATA_W-1:0] rdData;
    logic [`BUS_ADDR_W-1:0] A;
    bus68020Pkg::xferSize   SIZ;
    logic                   RnW;
    logic                   nAS;
    logic                   nDS;
    logic                   dOe;
    logic [`BUS_DATA_W-1:0] dOut;
    logic [`BUS_DATA_W-1:0] dIn = '0;
    bus68020Pkg::dsackCode  nDSACK = bus68020Pkg::dsackWait;

    logic [7:0]  slaveMem [MemBytes];
    logic [7:0]  refMem [MemBytes];
    int          slavePort;
    int          waitLeft;
    logic        inCycle;
    logic [31:0] waitSeed;
    logic [31:0] stimSeed;
    int          nasFalls;
    int          doneCount;
    int          issued;
    int          mismatches;
    int          failures;
    string       expName [$];
    logic        expWrite [$];
    logic [31:0] expData [$];
    int          expCycles [$];

    bus68020 UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus68020Pkg::xferSize sizeCode(input int n);
        case (n)
            1:       return bus68020Pkg::size1;
            2:       return bus68020Pkg::size2;
            3:       return bus68020Pkg::size3;
            default: return bus68020Pkg::size4;
        endcase
    endfunction

    function automatic bus68020Pkg::dsackCode portCode(input int p);
        case (p)
            `PORT8_BYTES:  return bus68020Pkg::dsack8;
            `PORT16_BYTES: return bus68020Pkg::dsack16;
            default:       return bus68020Pkg::dsack32;
        endcase
    endfunction

    // Reference model that returns the bus cycle count and updates refMem on writes
    function automatic int predict(input logic wr, input int addr, input int n, input int p,
                                   input logic [31:0] data, output logic [31:0] rd);
        int cycles;
        int a;
        int r;
        int m;
        rd = '0;
        for (int k = 0; k < n; k++) begin
            if (wr) begin
                refMem[addr + k] = data[8 * (n - 1 - k) +: 8];  // Big-endian operand
            end else begin
                rd = (rd << 8) | 32'(refMem[addr + k]);
            end
        end
        cycles = 0;
        a = addr;
        r = n;
        while (r > 0) begin
            m = p - a % p;
            if (r < m) begin
                m = r;
            end
            a += m;
            r -= m;
            cycles++;
        end
        return cycles;
    endfunction

    // Slave port lanes start at D[31:24] for every width
    always @(negedge CLK) begin
        int off;
        int base;
        int r;
        int m;
        if (!in_RESET || nAS) begin
            inCycle = 1'b0;
            nDSACK  = bus68020Pkg::dsackWait;
        end else begin
            if (!inCycle) begin
                inCycle  = 1'b1;
                nasFalls++;
                waitSeed = lcgNext(waitSeed);
                waitLeft = int'(waitSeed[23:16]) % (`TB_MAX_WAIT + 1);
            end
            if (waitLeft > 0) begin
                waitLeft--;
                nDSACK = bus68020Pkg::dsackWait;
            end else begin
                off  = int'(A[7:0]) % slavePort;
                base = int'(A[7:0]) - off;
                r    = (SIZ == bus68020Pkg::size4) ? 4 : int'(SIZ);
                m    = (r < slavePort - off) ? r : slavePort - off;
                nDSACK = portCode(slavePort);
                if (RnW) begin
                    dIn = 32'hdead_beef;  // Junk on lanes the port leaves alone
                    for (int j = 0; j < slavePort; j++) begin
                        dIn[8 * (3 - j) +: 8] = slaveMem[base + j];
                    end
                end else begin
                    assert (dOe) else begin
                        failures++;
                        $display("Write cycle at address %0d ran without dOe", A);
                    end
                    for (int j = off; j < off + m; j++) begin
                        slaveMem[base + j] = dOut[8 * (3 - j) +: 8];
                    end
                end
            end
        end
    end

    always @(negedge CLK) begin
        string       name;
        logic        wr;
        logic [31:0] expRd;
        int          cycles;
        if (in_RESET && done) begin
            doneCount++;
            if (expName.size() == 0) begin
                failures++;
                $display("A done pulse arrived with no request outstanding");
            end else begin
                name   = expName.pop_front();
                wr     = expWrite.pop_front();
                expRd  = expData.pop_front();
                cycles = expCycles.pop_front();
                assert (nasFalls == cycles) else begin
                    mismatches++;
                    $display("Mismatch %s bus cycles: expected %0d, actual %0d",
                             name, cycles, nasFalls);
                end
                if (wr) begin
                    for (int i = 0; i < MemBytes; i++) begin
                        assert (slaveMem[i] == refMem[i]) else begin
                            mismatches++;
                            $display("Mismatch %s mem[%0d]: expected %h, actual %h",
                                     name, i, refMem[i], slaveMem[i]);
                        end
                    end
                end else begin
                    assert (rdData == expRd) else begin
                        mismatches++;
                        $display("Mismatch %s: expected %h, actual %h", name, expRd, rdData);
                    end
                end
            end
            nasFalls = 0;
        end
    end

    task automatic runRequest(input string name, input logic wr, input int addr, input int n,
                              input int p, input logic [31:0] data, input logic noisy);
        logic [31:0] rd;
        int          cycles;
        @(negedge CLK);
        slavePort = p;
        cycles = predict(wr, addr, n, p, data, rd);
        expName.push_back(name);
        expWrite.push_back(wr);
        expData.push_back(rd);
        expCycles.push_back(cycles);
        reqValid = 1'b1;
        reqWrite = wr;
        reqAddr  = 32'(addr);
        reqSize  = sizeCode(n);
        reqData  = data;
        issued++;
        do begin
            @(negedge CLK);
            stimSeed = lcgNext(stimSeed);
            reqValid = noisy && busy && !done && stimSeed[20];  // Must be ignored
            if (reqValid) begin
                reqWrite = stimSeed[21];
                reqData  = stimSeed;
            end
        end while (!done);
    endtask

    initial begin
        int          ports [3];
        int          addr;
        int          n;
        int          p;
        logic        wr;
        logic [31:0] data;
        ports     = '{`PORT8_BYTES, `PORT16_BYTES, `PORT32_BYTES};
        in_RESET  = 1'b0;
        reqValid  = 1'b0;
        reqWrite  = 1'b0;
        reqAddr   = '0;
        reqData   = '0;
        reqSize   = bus68020Pkg::size1;
        slavePort = `PORT32_BYTES;
        waitLeft  = 0;
        inCycle   = 1'b0;
        waitSeed  = 32'h67234b03;
        stimSeed  = 32'h67234b03;
        nasFalls  = 0;
        doneCount = 0;
        issued    = 0;
        mismatches = 0;
        failures  = 0;
        for (int i = 0; i < MemBytes; i++) begin
            slaveMem[i] = 8'((i * 53) ^ 8'h2d);
            refMem[i]   = slaveMem[i];
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        in_RESET = 1'b1;
        @(negedge CLK);
        assert (nAS && nDS && RnW && !busy && !done && !dOe && A == '0
                && SIZ == bus68020Pkg::size4) else begin
            failures++;
            $display("Bus outputs were not idle after reset");
        end
        for (int pi = 0; pi < 3; pi++) begin
            for (n = 1; n <= 4; n = n * 2) begin
                runRequest($sformatf("aligned read port%0d size%0d", ports[pi] * 8, n),
                           1'b0, 4 * (pi * 4 + n), n, ports[pi], '0, 1'b0);
            end
        end
        for (int pi = 0; pi < 3; pi++) begin
            for (n = 1; n <= 4; n++) begin
                for (int off = 0; off < 4; off++) begin
                    runRequest($sformatf("read port%0d size%0d addr%0d", ports[pi] * 8, n,
                               32 + 8 * n + off), 1'b0, 32 + 8 * n + off, n, ports[pi], '0, 1'b0);
                end
            end
        end
        for (int pi = 0; pi < 3; pi++) begin
            for (n = 1; n <= 4; n++) begin
                for (int off = 0; off < 4; off++) begin
                    stimSeed = lcgNext(stimSeed);
                    runRequest($sformatf("write port%0d size%0d addr%0d", ports[pi] * 8, n,
                               96 + 8 * n + off), 1'b1, 96 + 8 * n + off, n, ports[pi],
                               stimSeed, 1'b0);
                end
            end
        end
        for (int i = 0; i < 200; i++) begin
            stimSeed = lcgNext(stimSeed);
            n    = 1 + int'(stimSeed[17:16]);
            p    = ports[int'(stimSeed[19:18]) % 3];
            addr = int'(stimSeed[27:20]) % (MemBytes - 4);
            wr   = stimSeed[28];
            stimSeed = lcgNext(stimSeed);
            data = stimSeed;
            runRequest($sformatf("random %0d", i), wr, addr, n, p, data, 1'b1);
        end
        repeat (4) @(negedge CLK);
        assert (doneCount == issued) else begin
            failures++;
            $display("Saw %0d done pulses for %0d requests", doneCount, issued);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/bus68020Pkg.sv
rtl/cycleIf.sv
rtl/sizingTracker.sv
rtl/cycleSequencer.sv
rtl/laneRouter.sv
rtl/bus68020.sv
sim/bus68020_assertions.sv
sim/tb_bus68020.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_bus68020 -o tb_bus68020 \
    && ./obj_dir/tb_bus68020 | tee /dev/stderr | grep -F -- "** PASS **" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
